// File: tb.f
src/fdc_pkg.sv
src/geom_pkg.sv
src/fdc_ifs.sv
src/fdc_regs.sv
src/fdc_sequencer.sv
src/sector_geometry.sv
src/sd_block_xfer.sv
src/sector_buffer.sv
src/fdc_top.sv
verif/fdc_sva.sv
verif/tb_fdc.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fdc -f tb.f -o sim_fdc
./obj_dir/sim_fdc > sim.log 2>&1 || true
cat sim.log
if grep -q "tests failed" sim.log; then
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

// File: verif/tb_fdc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fdc
	import fdc_pkg::*, geom_pkg::*;
();
	localparam int STEP_CLKS = 4;
	localparam int SECTOR_BYTES = 512;
	localparam int SPT_CODE2 = 9; // size_code 2 is 9 sectors of 512.
	localparam int STEP_WAITS = 4 * (2 + 30 * STEP_CLKS);
	localparam int TIMEOUT_CYCLES = 20 * (SECTOR_BYTES * 8 + STEP_WAITS);

	logic       clk_sys;
	logic       disk_change_reset_n;
	logic       io_en, rd, wr;
	logic [1:0] addr;
	logic [7:0] din;
	wire  [7:0] dout;
	wire        drq, intrq, busy;
	logic       wp;
	size_code_t size_code;
	logic       side, ready;
	wire        ready_n, disk_change_n;
	logic       img_mounted;
	wire [31:0] sd_lba;
	wire        sd_rd, sd_wr;
	logic       sd_ack;
	logic [8:0] sd_buff_addr;
	logic [7:0] sd_buff_dout;
	wire  [7:0] sd_buff_din;
	logic       sd_buff_wr;

	logic [7:0]  pattern [0:1023]; // low half from the card, high half from the host.
	logic [7:0]  sd_capture [0:511];
	logic [31:0] sd_rd_lba = 32'd0;
	logic [31:0] sd_wr_lba = 32'd0;
	int          sd_rd_count = 0;
	int          sd_wr_count = 0;
	int          cycle_count = 0;
	int          err_count = 0;

	fdc_top #(.STEP_CLKS(STEP_CLKS)) fdc_top_inst (
		.clk_sys, .disk_change_reset_n, .io_en, .rd, .wr, .addr, .din, .dout,
		.drq, .intrq, .busy, .wp, .size_code, .side, .ready, .ready_n,
		.disk_change_n, .img_mounted, .sd_lba, .sd_rd, .sd_wr, .sd_ack,
		.sd_buff_addr, .sd_buff_dout, .sd_buff_din, .sd_buff_wr
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: no result after %0d cycles", cycle_count);
			$display("tests failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// image sector index times sector size, in 512-byte blocks.
	function automatic logic [31:0] expected_lba(input int trk, input int sd, input int spt,
		input int sec, input int bytes);
		return ((2 * trk + sd) * spt + sec - 1) * bytes / 512;
	endfunction

	task automatic fill_pattern();
		logic [31:0] lfsr;
		logic [7:0]  b;
		lfsr = 32'hc757dcb0;
		for (int n = 0; n < 2 * SECTOR_BYTES; n++) begin
			for (int k = 0; k < 8; k++) begin
				lfsr = lfsr_step(lfsr);
				b[k] = lfsr[0];
			end
			pattern[n] = b;
		end
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			err_count++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic write_reg(input reg_addr_t a, input logic [7:0] value);
		@(negedge clk_sys);
		addr = a;
		din = value;
		io_en = 1'b1;
		wr = 1'b1;
		@(negedge clk_sys);
		wr = 1'b0;
		io_en = 1'b0;
		@(negedge clk_sys); // falling strobe reaches the sequencer.
	endtask

	task automatic read_reg(input reg_addr_t a, output logic [7:0] value);
		@(negedge clk_sys);
		addr = a;
		io_en = 1'b1;
		rd = 1'b1;
		@(negedge clk_sys);
		value = dout;
		rd = 1'b0;
		io_en = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic await_drq();
		@(negedge clk_sys);
		while (!drq)
			@(negedge clk_sys);
	endtask

	task automatic wait_intrq();
		@(negedge clk_sys);
		while (!intrq)
			@(negedge clk_sys);
	endtask

	task automatic answer_sd_read();
		sd_rd_lba = sd_lba;
		sd_rd_count++;
		sd_ack = 1'b1;
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			sd_buff_addr = i[8:0];
			sd_buff_dout = pattern[i];
			sd_buff_wr = 1'b1;
			@(negedge clk_sys);
		end
		sd_buff_wr = 1'b0;
		sd_ack = 1'b0;
	endtask

	task automatic capture_sd_write();
		sd_wr_lba = sd_lba;
		sd_wr_count++;
		sd_ack = 1'b1;
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			sd_buff_addr = i[8:0];
			@(negedge clk_sys);
			sd_capture[i] = sd_buff_din; // registered read, one cycle late.
		end
		sd_ack = 1'b0;
	endtask

	// card model.
	always @(negedge clk_sys) begin
		if (sd_rd && !sd_ack)
			answer_sd_read();
		else if (sd_wr && !sd_ack)
			capture_sd_write();
	end

	// read and write never requested together.
	always @(negedge clk_sys) begin
		if (disk_change_reset_n)
			compare("sd_rd_wr_exclusive", 0, sd_rd & sd_wr);
	end

	task automatic seek_track(input logic [7:0] t);
		write_reg(A_DATA, t);
		write_reg(A_CMD_STATUS, 8'h10);
		wait_intrq();
	endtask

	task automatic reset_and_seek();
		logic [7:0] value;
		int         cycles;
		compare("reset_outputs", 32'd0, {busy, drq, intrq, sd_rd, sd_wr});
		read_reg(A_CMD_STATUS, value);
		compare("reset_status", 8'h00, value);
		write_reg(A_TRACK, 8'd5);
		write_reg(A_CMD_STATUS, 8'h00);
		wait_intrq();
		read_reg(A_TRACK, value);
		compare("restore_track", 8'd0, value);
		read_reg(A_CMD_STATUS, value);
		compare("restore_track0", 1, value[ST_TRACK0_LOST]);
		write_reg(A_DATA, 8'd42);
		@(negedge clk_sys);
		addr = A_CMD_STATUS;
		din = 8'h10; // seek, rate 0.
		io_en = 1'b1;
		wr = 1'b1;
		@(posedge clk_sys);
		cycles = 0;
		@(negedge clk_sys);
		wr = 1'b0;
		io_en = 1'b0;
		while (!intrq) begin
			cycles++;
			@(negedge clk_sys);
		end
		compare("seek_intrq_delay", 2 + 6 * STEP_CLKS, cycles);
		read_reg(A_TRACK, value);
		compare("seek_track", 8'd42, value);
	endtask

	task automatic read_sector_check();
		logic [7:0] value;
		int         rd_before;
		size_code = 3'd2;
		side = 1'b1;
		seek_track(8'd3);
		write_reg(A_SECTOR, 8'd4);
		rd_before = sd_rd_count;
		write_reg(A_CMD_STATUS, 8'h80);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			await_drq();
			read_reg(A_DATA, value);
			compare("read_data", pattern[i], value);
		end
		wait_intrq();
		compare("read_busy_end", 0, busy);
		compare("read_sd_requests", rd_before + 1, sd_rd_count);
		compare("read_lba", expected_lba(3, 1, SPT_CODE2, 4, SECTOR_BYTES), sd_rd_lba);
	endtask

	task automatic write_sector_check();
		logic [7:0] value;
		int         wr_before;
		wr_before = sd_wr_count;
		write_reg(A_CMD_STATUS, 8'ha0);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			await_drq();
			write_reg(A_DATA, pattern[SECTOR_BYTES + i]);
		end
		wait_intrq();
		compare("write_sd_requests", wr_before + 1, sd_wr_count);
		compare("write_lba", expected_lba(3, 1, SPT_CODE2, 4, SECTOR_BYTES), sd_wr_lba);
		for (int i = 0; i < SECTOR_BYTES; i++)
			compare("write_data", pattern[SECTOR_BYTES + i], sd_capture[i]);
		read_reg(A_CMD_STATUS, value);
		compare("write_error_bits", 8'h00, value & 8'h7c);
	endtask

	task automatic fault_cases();
		logic [7:0] value;
		int         wr_before, rd_before;
		wp = 1'b1;
		wr_before = sd_wr_count;
		write_reg(A_CMD_STATUS, 8'ha0);
		wait_intrq();
		read_reg(A_CMD_STATUS, value);
		compare("wprot_status", 1, value[ST_WPROT]);
		compare("wprot_fault", 1, value[ST_HEADLOADED_WF]);
		compare("wprot_no_sd_write", wr_before, sd_wr_count);
		wp = 1'b0;
		write_reg(A_SECTOR, 8'd10); // past the 9 sectors of code 2.
		rd_before = sd_rd_count;
		write_reg(A_CMD_STATUS, 8'h80);
		wait_intrq();
		read_reg(A_CMD_STATUS, value);
		compare("rnf_status", 1, value[ST_RNF]);
		compare("rnf_no_sd_read", rd_before, sd_rd_count);
		ready = 1'b0;
		read_reg(A_CMD_STATUS, value);
		compare("not_ready_status", 1, value[ST_NOT_READY]);
		compare("ready_n_out", 1, ready_n);
		ready = 1'b1;
	endtask

	task automatic force_interrupt_check();
		logic [7:0] value;
		write_reg(A_SECTOR, 8'd4);
		write_reg(A_CMD_STATUS, 8'h80);
		await_drq();
		read_reg(A_DATA, value);
		compare("force_first_byte", pattern[0], value);
		await_drq();
		compare("force_intrq_before", 0, intrq);
		write_reg(A_CMD_STATUS, 8'hd0);
		wait_intrq();
		compare("force_busy_drq", 0, {busy, drq});
	endtask

	task automatic disk_change_check();
		compare("disk_change_idle", 1, disk_change_n);
		@(negedge clk_sys);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		compare("disk_change_low", 0, disk_change_n);
		disk_change_reset_n = 1'b0;
		repeat (5) @(negedge clk_sys);
		disk_change_reset_n = 1'b1;
		compare("disk_change_cleared", 1, disk_change_n);
		compare("reset_outputs_again", 32'd0, {busy, drq, intrq, sd_rd, sd_wr});
	endtask

	initial begin
		clk_sys = 1'b0;
		disk_change_reset_n = 1'b0;
		io_en = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = 2'd0;
		din = 8'd0;
		wp = 1'b0;
		size_code = 3'd2;
		side = 1'b0;
		ready = 1'b1;
		img_mounted = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = 9'd0;
		sd_buff_dout = 8'd0;
		sd_buff_wr = 1'b0;
		fill_pattern();
		repeat (5) @(negedge clk_sys);
		disk_change_reset_n = 1'b1;
		reset_and_seek();
		read_sector_check();
		write_sector_check();
		fault_cases();
		force_interrupt_check();
		disk_change_check();
		if (err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end
endmodule

`default_nettype wire

// File: verif/fdc_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_sva (
	input wire clk_sys,
	input wire disk_change_reset_n,
	input wire busy,
	input wire drq,
	input wire intrq
);
	drq_needs_busy: assert property (@(posedge clk_sys) disable iff (!disk_change_reset_n)
		drq |-> busy) else $error("drq high while not busy");

	// a command ends with both edges together.
	intrq_ends_busy: assert property (@(posedge clk_sys) disable iff (!disk_change_reset_n)
		$rose(intrq) |-> $fell(busy)) else $error("intrq rose without busy falling");
endmodule

bind fdc_sequencer fdc_sva sva_inst (
	.clk_sys(clk_sys),
	.disk_change_reset_n(disk_change_reset_n),
	.busy(busy),
	.drq(drq),
	.intrq(intrq)
);

`default_nettype wire

// File: src/fdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_top
	import geom_pkg::*;
#(
	parameter int STEP_CLKS = 32000
) (
	input  wire             clk_sys,
	input  wire             disk_change_reset_n,
	input  wire             io_en,
	input  wire             rd,
	input  wire             wr,
	input  wire [1:0]       addr,
	input  wire [7:0]       din,
	output wire [7:0]       dout,
	output wire             drq,
	output wire             intrq,
	output wire             busy,
	input  wire             wp,
	input  wire size_code_t size_code,
	input  wire             side,
	input  wire             ready,
	output wire             ready_n,
	output wire             disk_change_n,
	input  wire             img_mounted,
	output wire [31:0]      sd_lba,
	output wire             sd_rd,
	output wire             sd_wr,
	input  wire             sd_ack,
	input  wire [8:0]       sd_buff_addr,
	input  wire [7:0]       sd_buff_dout,
	output wire [7:0]       sd_buff_din,
	input  wire             sd_buff_wr
);
	buf_port_if buf_port ();
	sd_req_if   sd_req ();

	logic [7:0] status, cmd_byte, track_reg, sector_reg, track_value, sector_value;
	logic       cmd_strobe, data_read_done, data_write_done, status_clear;
	logic       track_load, sector_load;
	logic [7:0] disk_track, geom_sector, sectors_per_track;
	logic [1:0] size_shift, block_count, sd_block;
	img_addr_t  byte_offset;

	fdc_regs regs_inst (
		.clk_sys, .disk_change_reset_n, .io_en, .rd, .wr, .addr, .din, .dout,
		.buf_host(buf_port.host), .status, .track_load, .sector_load,
		.track_value, .sector_value, .busy, .cmd_strobe, .cmd_byte,
		.data_read_done, .data_write_done, .status_clear, .track_reg, .sector_reg
	);

	fdc_sequencer #(.STEP_CLKS(STEP_CLKS)) seq_inst (
		.clk_sys, .disk_change_reset_n, .cmd_strobe, .cmd_byte,
		.data_read_done, .data_write_done, .status_clear, .track_reg, .sector_reg,
		.track_load, .sector_load, .track_value, .sector_value,
		.wp, .ready, .img_mounted, .byte_offset, .sectors_per_track, .size_shift,
		.block_count, .disk_track, .geom_sector, .buf_seq(buf_port.seq),
		.sd_req(sd_req.seq), .status, .busy, .drq, .intrq, .ready_n, .disk_change_n
	);

	sector_geometry geom_inst (
		.clk_sys, .size_code, .side, .disk_track, .sector(geom_sector),
		.byte_offset, .sectors_per_track, .size_shift, .block_count
	);

	sd_block_xfer xfer_inst (
		.clk_sys, .disk_change_reset_n, .req(sd_req.xfer), .sd_ack,
		.sd_rd, .sd_wr, .sd_lba, .sd_block
	);

	sector_buffer buf_inst (
		.clk_sys, .sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .sd_ack, .sd_block,
		.sd_buff_din, .host(buf_port.mem)
	);
endmodule

`default_nettype wire

// File: src/sector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sector_buffer (
	input  wire        clk_sys,
	input  wire [8:0]  sd_buff_addr,
	input  wire [7:0]  sd_buff_dout,
	input  wire        sd_buff_wr,
	input  wire        sd_ack,
	input  wire [1:0]  sd_block,
	output logic [7:0] sd_buff_din,
	buf_port_if.mem    host
);
	logic [7:0]  ram [0:4095];
	logic [11:0] addr_a;

	assign addr_a = {1'b0, sd_block, sd_buff_addr}; // block index on the upper bits.

	// sd side, writes only inside an acknowledged transfer.
	always @(posedge clk_sys) begin
		sd_buff_din <= ram[addr_a];
		if (sd_buff_wr && sd_ack)
			ram[addr_a] <= sd_buff_dout;
	end

	always @(posedge clk_sys) begin
		host.rdata <= ram[host.addr]; // old data on a write.
		if (host.we)
			ram[host.addr] <= host.wdata;
	end
endmodule

`default_nettype wire

// File: src/sd_block_xfer.sv
`timescale 1ns/1ps
`default_nettype none

module sd_block_xfer (
	input  wire         clk_sys,
	input  wire         disk_change_reset_n,
	sd_req_if.xfer      req,
	input  wire         sd_ack,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic [31:0] sd_lba,
	output logic [1:0]  sd_block
);
	logic [5:0]  ack_sr; // ack synchronizer.
	logic        ack_rise, ack_fall;
	logic        active, dir_wr, done_r;
	logic [1:0]  last_block;
	logic [31:0] base_lba;

	assign ack_rise = ack_sr[5:4] == 2'b01;
	assign ack_fall = ack_sr[5:4] == 2'b10;

	always_ff @(posedge clk_sys) begin
		if (!disk_change_reset_n) begin
			ack_sr <= 6'd0;
			{sd_rd, sd_wr, active, dir_wr, done_r} <= '0;
			sd_block <= 2'd0;
			last_block <= 2'd0;
			base_lba <= 32'd0;
		end else begin
			ack_sr <= {ack_sr[4:0], sd_ack};
			done_r <= 1'b0;
			if (req.start_rd || req.start_wr) begin
				active <= 1'b1;
				dir_wr <= req.start_wr;
				sd_rd <= req.start_rd;
				sd_wr <= req.start_wr;
				sd_block <= 2'd0;
				last_block <= req.block_count;
				base_lba <= req.lba;
			end else if (active) begin
				if (ack_rise) begin
					sd_rd <= 1'b0; // request seen.
					sd_wr <= 1'b0;
				end
				if (ack_fall) begin
					if (sd_block == last_block) begin
						active <= 1'b0;
						done_r <= 1'b1;
					end else begin
						sd_block <= sd_block + 2'd1;
						sd_rd <= ~dir_wr;
						sd_wr <= dir_wr;
					end
				end
			end
		end
	end

	assign sd_lba = base_lba + 32'(sd_block);
	assign req.done = done_r;
endmodule

`default_nettype wire

// File: src/sector_geometry.sv
`timescale 1ns/1ps
`default_nettype none

module sector_geometry
	import geom_pkg::*;
(
	input  wire             clk_sys,
	input  wire size_code_t size_code,
	input  wire             side,
	input  wire [7:0]       disk_track,
	input  wire [7:0]       sector,
	output img_addr_t       byte_offset,
	output logic [7:0]      sectors_per_track,
	output logic [1:0]      size_shift,
	output logic [1:0]      block_count
);
	geom_t      geom;
	logic [8:0]  side_track;
	logic [16:0] sec_index;
	logic [23:0] sec_bytes;
	img_addr_t   offset_next;
	logic [1:0]  blocks_next;

	always_comb begin
		geom = GEOM_TABLE[size_code];
		side_track = {disk_track, side}; // 2 * track + side.
		sec_index = side_track * geom.sectors_per_track + sector - 17'd1;
		sec_bytes = {sec_index, 7'd0} << geom.size_shift;
		offset_next = sec_bytes[20:0];
		// extra 512-byte blocks the sector spans.
		case (geom.size_shift)
			2'd3: blocks_next = 2'd1; // 1024 bytes, always two aligned blocks.
			default: blocks_next = 2'd0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		byte_offset <= offset_next;
		sectors_per_track <= geom.sectors_per_track;
		size_shift <= geom.size_shift;
		block_count <= blocks_next;
	end
endmodule

`default_nettype wire

// File: src/fdc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_sequencer
	import fdc_pkg::*, geom_pkg::*;
#(
	parameter int STEP_CLKS = 32000
) (
	input  wire            clk_sys,
	input  wire            disk_change_reset_n,
	input  wire            cmd_strobe,
	input  wire [7:0]      cmd_byte,
	input  wire            data_read_done,
	input  wire            data_write_done,
	input  wire            status_clear,
	input  wire [7:0]      track_reg,
	input  wire [7:0]      sector_reg,
	output logic           track_load,
	output logic           sector_load,
	output logic [7:0]     track_value,
	output logic [7:0]     sector_value,
	input  wire            wp,
	input  wire            ready,
	input  wire            img_mounted,
	input  wire img_addr_t byte_offset,
	input  wire [7:0]      sectors_per_track,
	input  wire [1:0]      size_shift,
	input  wire [1:0]      block_count,
	output logic [7:0]     disk_track,
	output logic [7:0]     geom_sector,
	buf_port_if.seq        buf_seq,
	sd_req_if.seq          sd_req,
	output logic [7:0]     status,
	output logic           busy,
	output logic           drq,
	output logic           intrq,
	output logic           ready_n,
	output logic           disk_change_n
);
	fdc_state_t  state;
	logic        cmd_type_1, cmd_type_wr, rnf, wrfault, headloaded, step_dir;
	logic        we, start_rd, start_wr, step_out;
	logic [31:0] wait_cnt, step_clks;
	logic [11:0] buf_addr;
	logic [10:0] remaining, sector_size;
	logic [7:0]  next_track;

	assign ready_n = ~ready;
	assign geom_sector = (sector_reg == 8'd0) ? 8'd1 : sector_reg; // sector 0 reads as 1.
	assign sector_value = 8'd1;
	assign sector_size = 11'd128 << size_shift;
	assign step_out = cmd_byte[6] ? cmd_byte[5] : step_dir;
	assign next_track = step_out ? ((disk_track != 8'd0) ? disk_track - 8'd1 : 8'd0)
		: disk_track + 8'd1;

	always_comb begin
		case (cmd_byte[1:0])
			2'd0: step_clks = 32'(6 * STEP_CLKS - 1);
			2'd1: step_clks = 32'(12 * STEP_CLKS - 1);
			2'd2: step_clks = 32'(20 * STEP_CLKS - 1);
			default: step_clks = 32'(30 * STEP_CLKS - 1);
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!disk_change_reset_n) begin
			state <= IDLE;
			{busy, drq, intrq, rnf, wrfault, headloaded} <= '0;
			{cmd_type_1, cmd_type_wr, step_dir, we, start_rd, start_wr} <= '0;
			{track_load, sector_load} <= '0;
			track_value <= 8'd0;
			disk_track <= 8'd0;
			wait_cnt <= 32'd0;
			buf_addr <= 12'd0;
			remaining <= 11'd0;
			disk_change_n <= 1'b1;
		end else begin
			{track_load, sector_load, start_rd, start_wr} <= '0;
			if (img_mounted)
				disk_change_n <= 1'b0;
			if (status_clear) begin
				intrq <= 1'b0;
				rnf <= 1'b0;
				wrfault <= 1'b0;
			end
			case (state)
				CHECK: begin
					if (!ready) begin
						if (cmd_type_wr)
							wrfault <= 1'b1;
						else
							rnf <= 1'b1;
						state <= DONE;
					end else if (geom_sector > sectors_per_track || track_reg > MAX_TRACK) begin
						rnf <= 1'b1;
						state <= DONE;
					end else begin
						sector_load <= sector_reg == 8'd0;
						start_rd <= 1'b1; // writes also fetch first, the sector may share a block.
						state <= SD_READ;
					end
				end
				SD_READ: if (sd_req.done) begin
					buf_addr <= {3'b000, byte_offset[8:0]};
					remaining <= sector_size;
					drq <= cmd_type_wr;
					state <= cmd_type_wr ? HOST_WRITE : HOST_READ;
				end
				HOST_READ: begin
					if (!drq) begin
						drq <= 1'b1; // rdata valid by now.
					end else if (data_read_done) begin
						drq <= 1'b0;
						buf_addr <= buf_addr + 12'd1;
						remaining <= remaining - 11'd1;
						if (remaining == 11'd1)
							state <= DONE;
					end
				end
				HOST_WRITE: begin
					if (we) begin
						we <= 1'b0;
						buf_addr <= buf_addr + 12'd1;
						remaining <= remaining - 11'd1;
						if (remaining == 11'd1) begin
							start_wr <= 1'b1;
							state <= SD_WRITE;
						end else begin
							drq <= 1'b1;
						end
					end else if (drq && data_write_done) begin
						we <= 1'b1;
						drq <= 1'b0;
					end
				end
				SD_WRITE: if (sd_req.done)
					state <= DONE;
				STEP_WAIT: begin
					if (wait_cnt != 32'd0)
						wait_cnt <= wait_cnt - 32'd1;
					else
						state <= DONE;
				end
				DONE: begin
					busy <= 1'b0;
					drq <= 1'b0;
					we <= 1'b0;
					intrq <= 1'b1;
					state <= IDLE;
				end
				default: ;
			endcase
			if (cmd_strobe) begin
				intrq <= 1'b0;
				if (cmd_byte[7:4] == CMD_FORCE_INT) begin
					busy <= 1'b1; // falls in DONE next cycle.
					cmd_type_1 <= 1'b1;
					cmd_type_wr <= 1'b0;
					state <= DONE;
				end else if (!busy) begin
					busy <= 1'b1;
					rnf <= 1'b0;
					wrfault <= 1'b0;
					cmd_type_1 <= ~cmd_byte[7];
					cmd_type_wr <= cmd_byte[7:5] == CMD_WRITE_SECTOR;
					if (!cmd_byte[7]) begin
						headloaded <= cmd_byte[3];
						wait_cnt <= step_clks;
						state <= STEP_WAIT;
						if (cmd_byte[7:4] == CMD_RESTORE) begin
							disk_track <= 8'd0;
							track_load <= 1'b1;
							track_value <= 8'd0;
						end else if (cmd_byte[7:4] == CMD_SEEK) begin
							disk_track <= buf_seq.wdata;
							track_load <= 1'b1;
							track_value <= buf_seq.wdata;
						end else begin
							if (cmd_byte[6])
								step_dir <= cmd_byte[5];
							disk_track <= next_track;
							track_load <= cmd_byte[4];
							track_value <= next_track;
						end
					end else if (cmd_byte[7:5] == CMD_READ_SECTOR) begin
						state <= CHECK;
					end else if (cmd_byte[7:5] == CMD_WRITE_SECTOR) begin
						wrfault <= wp;
						state <= wp ? DONE : CHECK;
					end else begin
						state <= DONE; // read address and track commands end at once.
					end
				end
			end
		end
	end

	always_comb begin
		status = 8'd0;
		status[ST_BUSY] = busy;
		status[ST_DRQ_INDEX] = cmd_type_1 ? 1'b0 : drq;
		status[ST_TRACK0_LOST] = cmd_type_1 && disk_track == 8'd0;
		status[ST_RNF] = rnf;
		status[ST_HEADLOADED_WF] = cmd_type_1 ? headloaded : wrfault;
		status[ST_WPROT] = (cmd_type_1 || cmd_type_wr) && wp;
		status[ST_NOT_READY] = ready_n;
	end

	assign buf_seq.addr = buf_addr;
	assign buf_seq.we = we;
	assign sd_req.lba = {20'd0, byte_offset[20:9]};
	assign sd_req.block_count = block_count;
	assign sd_req.start_rd = start_rd;
	assign sd_req.start_wr = start_wr;
endmodule

`default_nettype wire

// File: src/fdc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_regs
	import fdc_pkg::*;
(
	input  wire        clk_sys,
	input  wire        disk_change_reset_n,
	input  wire        io_en,
	input  wire        rd,
	input  wire        wr,
	input  wire [1:0]  addr,
	input  wire [7:0]  din,
	output logic [7:0] dout,
	buf_port_if.host   buf_host,
	input  wire [7:0]  status,
	input  wire        track_load,
	input  wire        sector_load,
	input  wire [7:0]  track_value,
	input  wire [7:0]  sector_value,
	input  wire        busy,
	output logic       cmd_strobe,
	output logic [7:0] cmd_byte,
	output logic       data_read_done,
	output logic       data_write_done,
	output logic       status_clear,
	output logic [7:0] track_reg,
	output logic [7:0] sector_reg
);
	logic       rde, wre, old_rd, old_wr;
	logic       rd_rise, wr_rise, rd_fall, wr_fall;
	reg_addr_t  cur_addr; // address seen at the strobe's rising edge.
	logic [7:0] data_reg;

	assign rde = rd & io_en;
	assign wre = wr & io_en;
	assign rd_rise = rde & ~old_rd;
	assign wr_rise = wre & ~old_wr;
	assign rd_fall = ~rde & old_rd;
	assign wr_fall = ~wre & old_wr;

	always_ff @(posedge clk_sys) begin
		if (!disk_change_reset_n) begin
			old_rd <= 1'b0;
			old_wr <= 1'b0;
			cur_addr <= A_CMD_STATUS;
			cmd_strobe <= 1'b0;
			data_read_done <= 1'b0;
			data_write_done <= 1'b0;
			status_clear <= 1'b0;
			track_reg <= 8'd0;
			sector_reg <= 8'd0;
		end else begin
			old_rd <= rde;
			old_wr <= wre;
			if (rd_rise || wr_rise)
				cur_addr <= reg_addr_t'(addr);
			cmd_strobe <= wr_rise && addr == A_CMD_STATUS;
			status_clear <= rd_fall && cur_addr == A_CMD_STATUS;
			data_read_done <= rd_fall && cur_addr == A_DATA;
			data_write_done <= wr_fall && cur_addr == A_DATA;
			// sequencer updates win over the host.
			if (track_load)
				track_reg <= track_value;
			else if (wr_rise && addr == A_TRACK && !busy)
				track_reg <= din;
			if (sector_load)
				sector_reg <= sector_value;
			else if (wr_rise && addr == A_SECTOR && !busy)
				sector_reg <= din;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise && addr == A_CMD_STATUS)
			cmd_byte <= din;
		if (wr_rise && addr == A_DATA)
			data_reg <= din;
	end

	assign buf_host.wdata = data_reg;

	always_comb begin
		case (reg_addr_t'(addr))
			A_CMD_STATUS: dout = status;
			A_TRACK:      dout = track_reg;
			A_SECTOR:     dout = sector_reg;
			default:      dout = busy ? buf_host.rdata : data_reg; // buffer during a transfer.
		endcase
	end
endmodule

`default_nettype wire

// File: src/fdc_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// host-side port of the sector buffer.
interface buf_port_if;
	logic [11:0] addr;
	logic [7:0]  wdata; // data register byte.
	logic        we;
	logic [7:0]  rdata; // one cycle after addr.

	modport seq (
		output addr,
		output we,
		input  wdata
	);
	modport host (
		output wdata,
		input  rdata
	);
	modport mem (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);
endinterface

// block request from the sequencer to the sd side.
interface sd_req_if;
	logic [31:0] lba;
	logic        start_rd;
	logic        start_wr;
	logic [1:0]  block_count; // extra blocks beyond the first.
	logic        done;

	modport seq (
		output lba,
		output start_rd,
		output start_wr,
		output block_count,
		input  done
	);
	modport xfer (
		input  lba,
		input  start_rd,
		input  start_wr,
		input  block_count,
		output done
	);
endinterface

`default_nettype wire

// File: src/geom_pkg.sv
`default_nettype none

package geom_pkg;

	typedef logic [2:0] size_code_t;

	// sector size is 128 << size_shift.
	typedef struct packed {
		logic [7:0] sectors_per_track;
		logic [1:0] size_shift;
	} geom_t;

	typedef logic [20:0] img_addr_t; // byte address inside the image.

	localparam geom_t GEOM_TABLE [8] = '{
		'{8'd26, 2'd0},
		'{8'd16, 2'd1},
		'{8'd9,  2'd2},
		'{8'd5,  2'd3},
		'{8'd10, 2'd2},
		'{8'd17, 2'd1},
		'{8'd9,  2'd2}, // unused codes fall back to 9 x 512.
		'{8'd9,  2'd2}
	};

endpackage

`default_nettype wire

// File: src/fdc_pkg.sv
`default_nettype none

package fdc_pkg;

	// host register select.
	typedef enum logic [1:0] {
		A_CMD_STATUS = 2'd0,
		A_TRACK      = 2'd1,
		A_SECTOR     = 2'd2,
		A_DATA       = 2'd3
	} reg_addr_t;

	typedef enum logic [2:0] {
		IDLE,
		CHECK,
		SD_READ,
		HOST_READ,
		HOST_WRITE,
		SD_WRITE,
		STEP_WAIT,
		DONE
	} fdc_state_t;

	// command opcodes, upper nibble or upper three bits.
	localparam logic [3:0] CMD_RESTORE      = 4'h0;
	localparam logic [3:0] CMD_SEEK         = 4'h1;
	localparam logic [3:0] CMD_FORCE_INT    = 4'hd;
	localparam logic [2:0] CMD_READ_SECTOR  = 3'b100;
	localparam logic [2:0] CMD_WRITE_SECTOR = 3'b101;

	// status bits. several change meaning between type I and type II.
	localparam int ST_BUSY          = 0;
	localparam int ST_DRQ_INDEX     = 1;
	localparam int ST_TRACK0_LOST   = 2;
	localparam int ST_RNF           = 4;
	localparam int ST_HEADLOADED_WF = 5;
	localparam int ST_WPROT         = 6;
	localparam int ST_NOT_READY     = 7;

	localparam logic [7:0] MAX_TRACK = 8'd84;

endpackage

`default_nettype wire
